//--- src.f
verilog/trs_io_pkg.sv
verilog/esp_spi_slave.sv
verilog/esp_cmd_parser.sv
verilog/z80_port_decode.sv
verilog/flash_spi_master.sv
verilog/trs_io_top.sv
bench/trs_io_checker.sv
bench/trs_io_asserts.sv
bench/trs_io_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f src.f \
  --top-module trs_io_tb \
  --Mdir obj_dir \
  -o trs_io_sim

./obj_dir/trs_io_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation finished without failure"
exit 0

//--- bench/trs_io_tb.sv
`default_nettype none
`timescale 1ns/100ps

module trs_io_tb;

  import trs_io_pkg::*;

  localparam int esp_req_cycles  = 50;
  localparam int flash_half_log2 = 3;
  localparam int half_cycles     = 1 << flash_half_log2;

  logic       clk;
  logic       cass_out_sel_n;
  logic       sck;
  logic       mosi;
  logic       cs;
  logic       miso;
  logic       esp_done;
  logic       esp_req;
  esp_op_e    esp_s;
  z80_io_t    z80_io;
  logic [7:0] z80_rdata;
  logic       z80_wait;
  logic       flash_cs_n;
  logic       flash_sck;
  logic       flash_si;
  logic       flash_so;
  logic       led_red;
  logic       led_green;
  logic       led_blue;
  logic       led_error;
  int         errors;
  integer     seed;

  // flash model state
  logic [7:0] model_byte;
  logic [7:0] si_byte;
  int         si_bits = 0;
  int         so_bits = 0;
  int         si_base;
  int         so_base;
  logic [2:0] so_idx;

  trs_io_top #(
    .esp_req_cycles  (esp_req_cycles),
    .flash_half_log2 (flash_half_log2)
  ) trs_io_top_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .mosi           (mosi),
    .cs             (cs),
    .miso           (miso),
    .esp_done       (esp_done),
    .esp_req        (esp_req),
    .esp_s          (esp_s),
    .z80_io         (z80_io),
    .z80_rdata      (z80_rdata),
    .z80_wait       (z80_wait),
    .flash_cs_n     (flash_cs_n),
    .flash_sck      (flash_sck),
    .flash_si       (flash_si),
    .flash_so       (flash_so),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .led_error      (led_error)
  );

  trs_io_checker #(
    .half_cycles    (half_cycles),
    .esp_req_cycles (esp_req_cycles)
  ) trs_io_checker_i (
    .clk        (clk),
    .miso       (miso),
    .esp_req    (esp_req),
    .esp_s      (esp_s),
    .z80_rdata  (z80_rdata),
    .z80_wait   (z80_wait),
    .flash_cs_n (flash_cs_n),
    .flash_sck  (flash_sck),
    .led_red    (led_red),
    .led_green  (led_green),
    .led_blue   (led_blue),
    .led_error  (led_error),
    .errors     (errors)
  );

  initial begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

  // flash device, MSB first in both directions
  always @(posedge flash_sck) begin
    si_byte <= {si_byte[6:0], flash_si};
    si_bits <= si_bits + 1;
  end

  always @(negedge flash_sck) begin
    so_bits <= so_bits + 1;
  end

  assign so_idx   = 3'(so_bits - so_base);
  assign flash_so = model_byte[~so_idx];

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  function automatic bit known_opcode(input logic [7:0] op);
    return op inside {8'd0, 8'd3, 8'd4, 8'd15, 8'd26, 8'd29, 8'd30, 8'd31};
  endfunction

  // ESP samples miso in the low phase before the next rising edge
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    rx   = 8'h00;
    mosi = tx[7];
    repeat (5) next_cycle();
    for (i = 7; i >= 0; i--) begin
      sck = 1'b1;
      repeat (5) next_cycle();
      sck = 1'b0;
      repeat (5) next_cycle();
      rx = {rx[6:0], miso};
      if (i > 0) begin
        mosi = tx[i-1];
      end
    end
    repeat (10) next_cycle();
  endtask

  // dummy byte is get_cookie, which is harmless
  task automatic spi_command(input logic [7:0] op, input bit has_param,
                             input logic [7:0] param, output logic [7:0] reply);
    logic [7:0] rx;
    cs = 1'b0;
    repeat (4) next_cycle();
    spi_byte(op, rx);
    if (has_param) begin
      spi_byte(param, rx);
    end
    spi_byte(8'h00, reply);
    cs = 1'b1;
    repeat (4) next_cycle();
  endtask

  task automatic z80_start(input logic [7:0] port, input logic [7:0] data, input bit is_in);
    z80_io.port  = port;
    z80_io.wdata = data;
    z80_io.in_n  = ~is_in;
    z80_io.out_n = is_in;
  endtask

  task automatic z80_release();
    z80_io.in_n  = 1'b1;
    z80_io.out_n = 1'b1;
    repeat (4) next_cycle();
  endtask

  task automatic z80_write(input logic [7:0] port, input logic [7:0] data);
    z80_start(port, data, 1'b0);
    repeat (4) next_cycle();
    z80_release();
  endtask

  task automatic wait_for_wait_high();
    int n;
    n = 0;
    while (!z80_wait) begin
      next_cycle();
      n++;
      if (n > 20) begin
        abort_on_timeout("z80_wait to rise");
      end
    end
  endtask

  // ESP side answers once the request pulse is over
  task automatic esp_handshake();
    int n;
    n = 0;
    while (esp_req) begin
      next_cycle();
      n++;
      if (n > esp_req_cycles + 20) begin
        abort_on_timeout("esp_req to fall");
      end
    end
    repeat (5) next_cycle();
    trs_io_checker_i.check_value("wait held before done", int'(z80_wait), 1);
    esp_done = 1'b1;
    n = 0;
    while (z80_wait) begin
      @(posedge clk);
      #1;
      n++;
      if (n > 10) begin
        abort_on_timeout("z80_wait to fall");
      end
    end
    #1;
    trs_io_checker_i.check_value("wait release in 2..3 cycles", int'(n >= 2 && n <= 3), 1);
    trs_io_checker_i.check_value("esp_s idle", int'(esp_s), 15);
    esp_done = 1'b0;
  endtask

  task automatic flash_exchange(input bit via_spi, output logic [7:0] got_so);
    logic [7:0] tx;
    logic [7:0] rx;
    logic [7:0] ctrl;
    int         first_rise;
    int         n;
    tx         = 8'($random(seed));
    model_byte = 8'($random(seed));
    ctrl       = 8'($random(seed)) | 8'h80;
    so_base    = so_bits;
    si_base    = si_bits;
    first_rise = trs_io_checker_i.rise_count();
    if (via_spi) begin
      spi_command(8'd29, 1'b1, ctrl, rx);
      spi_command(8'd30, 1'b1, tx, rx);
    end else begin
      z80_write(port_spi_ctrl, ctrl);
      z80_write(port_spi_data, tx);
    end
    trs_io_checker_i.check_value("flash_cs_n low", int'(flash_cs_n), 0);
    n = 0;
    while (si_bits - si_base < 8 || flash_sck) begin
      next_cycle();
      n++;
      if (n > 40 * half_cycles) begin
        abort_on_timeout("end of flash transfer");
      end
    end
    repeat (4) next_cycle();
    trs_io_checker_i.check_value("flash_si byte", int'(si_byte), int'(tx));
    trs_io_checker_i.check_flash_timing(first_rise);
    got_so = model_byte;
  endtask

  initial begin
    logic [7:0] rx;
    logic [7:0] val;
    logic [7:0] so;
    int         i;
    seed           = 30;
    cass_out_sel_n = 1'b0;
    sck            = 1'b0;
    mosi           = 1'b0;
    cs             = 1'b1;
    esp_done       = 1'b0;
    z80_io         = '{port: 8'h00, wdata: 8'h00, in_n: 1'b1, out_n: 1'b1};
    model_byte     = 8'h00;
    si_base        = 0;
    so_base        = 0;
    repeat (16) @(posedge clk);
    #2;
    cass_out_sel_n = 1'b1;
    repeat (4) next_cycle();
    trs_io_checker_i.check_reset_state();
    trs_io_checker_i.end_test("reset state");

    spi_command(8'd0, 1'b0, 8'h00, rx);
    trs_io_checker_i.check_value("cookie", int'(rx), 8'hAF);
    spi_command(8'd15, 1'b0, 8'h00, rx);
    trs_io_checker_i.check_value("version", int'(rx), 8'h03);
    trs_io_checker_i.end_test("cookie and version");

    for (i = 0; i < 4; i++) begin
      val = 8'($random(seed));
      spi_command(8'd26, 1'b1, val, rx);
      trs_io_checker_i.check_leds(val[2:0]);
    end
    trs_io_checker_i.check_value("led_error off", int'(led_error), 0);
    val = 8'($random(seed));
    while (known_opcode(val)) begin
      val = val + 8'd1;
    end
    spi_command(val, 1'b0, 8'h00, rx);
    trs_io_checker_i.check_value("led_error on", int'(led_error), 1);
    trs_io_checker_i.end_test("leds");

    val = 8'($random(seed));
    spi_command(8'd4, 1'b1, val, rx);
    z80_start(port_trs_io, 8'h00, 1'b1);
    wait_for_wait_high();
    trs_io_checker_i.check_value("esp_s on IN", int'(esp_s), 0);
    esp_handshake();
    trs_io_checker_i.check_req_len();
    trs_io_checker_i.check_value("z80_rdata", int'(z80_rdata), int'(val));
    z80_release();
    trs_io_checker_i.end_test("dbus_write then Z80 IN");

    val = 8'($random(seed));
    z80_start(port_trs_io, val, 1'b0);
    wait_for_wait_high();
    trs_io_checker_i.check_value("esp_s on OUT", int'(esp_s), 1);
    esp_handshake();
    trs_io_checker_i.check_req_len();
    z80_release();
    spi_command(8'd3, 1'b0, 8'h00, rx);
    trs_io_checker_i.check_value("dbus_read", int'(rx), int'(val));
    trs_io_checker_i.end_test("Z80 OUT then dbus_read");

    flash_exchange(1'b0, so);
    z80_start(port_spi_data, 8'h00, 1'b1);
    repeat (3) next_cycle();
    trs_io_checker_i.check_value("flash byte on port FD", int'(z80_rdata), int'(so));
    z80_release();
    trs_io_checker_i.end_test("flash from Z80");

    flash_exchange(1'b1, so);
    spi_command(8'd31, 1'b0, 8'h00, rx);
    trs_io_checker_i.check_value("get_spi_data", int'(rx), int'(so));
    trs_io_checker_i.end_test("flash from ESP");

    trs_io_checker_i.report();
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/trs_io_asserts.sv
`default_nettype none
`timescale 1ns/100ps

module trs_io_asserts #(
  parameter int esp_req_cycles = 50
) (
  input wire logic clk,
  input wire logic cass_out_sel_n,
  input wire logic z80_wait,
  input wire logic esp_req,
  input wire logic flash_cs_n,
  input wire logic flash_sck
);

  logic req_seen;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      req_seen <= 1'b0;
    end else if (esp_req) begin
      req_seen <= 1'b1;
    end
  end

  // WAIT stays low from reset until the first ESP request
  a_wait_after_reset: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    !req_seen && !esp_req |-> !z80_wait)
    else $error("z80_wait high after reset before any ESP request");

  // pulse must have started exactly esp_req_cycles ago
  a_req_length: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    $fell(esp_req) |-> $past(esp_req, esp_req_cycles) && !$past(esp_req, esp_req_cycles + 1))
    else $error("esp_req pulse has wrong length");

  a_sck_idle: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    flash_cs_n |-> !flash_sck)
    else $error("flash_sck toggles while flash_cs_n is high");

endmodule

bind trs_io_top trs_io_asserts #(
  .esp_req_cycles (esp_req_cycles)
) trs_io_asserts_i (
  .clk            (clk),
  .cass_out_sel_n (cass_out_sel_n),
  .z80_wait       (z80_wait),
  .esp_req        (esp_req),
  .flash_cs_n     (flash_cs_n),
  .flash_sck      (flash_sck)
);

`default_nettype wire

//--- bench/trs_io_checker.sv
`default_nettype none
`timescale 1ns/100ps

module trs_io_checker #(
  parameter int half_cycles    = 8,
  parameter int esp_req_cycles = 50
) (
  input  wire logic       clk,
  input  wire logic       miso,
  input  wire logic       esp_req,
  input  wire logic [3:0] esp_s,
  input  wire logic [7:0] z80_rdata,
  input  wire logic       z80_wait,
  input  wire logic       flash_cs_n,
  input  wire logic       flash_sck,
  input  wire logic       led_red,
  input  wire logic       led_green,
  input  wire logic       led_blue,
  input  wire logic       led_error,
  output int              errors
);

  int   cycle = 0;
  int   req_run = 0;
  int   last_req_len = 0;
  int   test_errors = 0;
  int   tests_run = 0;
  int   tests_failed = 0;
  int   rise_at[$];
  int   fall_at[$];
  logic sck_q = 1'b0;

  initial begin
    errors = 0;
  end

  // sampled away from the active edge
  always @(negedge clk) begin
    cycle <= cycle + 1;
    sck_q <= flash_sck;
    if (flash_sck && !sck_q) begin
      rise_at.push_back(cycle);
    end
    if (!flash_sck && sck_q) begin
      fall_at.push_back(cycle);
    end
    if (esp_req) begin
      req_run <= req_run + 1;
    end else if (req_run != 0) begin
      last_req_len <= req_run;
      req_run      <= 0;
    end
  end

  task check_value(input string what, input int got, input int expected);
    if (got != expected) begin
      $display("FAILED at %0d ns: %s got %0h expected %0h", $time, what, got, expected);
      errors      = errors + 1;
      test_errors = test_errors + 1;
    end
  endtask

  task check_reset_state();
    check_value("esp_req after reset", int'(esp_req), 0);
    check_value("z80_wait after reset", int'(z80_wait), 0);
    check_value("esp_s after reset", int'(esp_s), 15);
    check_value("flash_cs_n after reset", int'(flash_cs_n), 1);
    check_value("flash_sck after reset", int'(flash_sck), 0);
    check_value("miso after reset", int'(miso), 0);
    check_value("leds after reset", int'({led_error, led_blue, led_green, led_red}), 0);
  endtask

  task check_leds(input logic [2:0] expected);
    check_value("rgb leds", int'({led_blue, led_green, led_red}), int'(expected));
  endtask

  task check_req_len();
    check_value("esp_req length", last_req_len, esp_req_cycles);
  endtask

  function int rise_count();
    return rise_at.size();
  endfunction

  // 16 half periods, the first one low before any rising edge
  task check_flash_timing(input int first);
    check_value("flash sck rising edges", rise_at.size() - first, 8);
    if (rise_at.size() - first == 8 && fall_at.size() > 0) begin
      check_value("flash transfer cycles",
                  fall_at[fall_at.size()-1] - rise_at[first] + half_cycles,
                  16 * half_cycles);
    end
  endtask

  task end_test(input string name);
    tests_run = tests_run + 1;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, test_errors);
      tests_failed = tests_failed + 1;
    end
    test_errors = 0;
  endtask

  task report();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
  endtask

endmodule

`default_nettype wire

//--- verilog/trs_io_top.sv
`default_nettype none
`timescale 1ns/100ps

module trs_io_top #(
  parameter int esp_req_cycles  = 50,
  parameter int flash_half_log2 = 3
) (
  input  wire logic                 clk,
  input  wire logic                 cass_out_sel_n,
  input  wire logic                 sck,
  input  wire logic                 mosi,
  input  wire logic                 cs,
  output logic                      miso,
  input  wire logic                 esp_done,
  output logic                      esp_req,
  output trs_io_pkg::esp_op_e       esp_s,
  input  wire trs_io_pkg::z80_io_t  z80_io,
  output logic [7:0]                z80_rdata,
  output logic                      z80_wait,
  output logic                      flash_cs_n,
  output logic                      flash_sck,
  output logic                      flash_si,
  input  wire logic                 flash_so,
  output logic                      led_red,
  output logic                      led_green,
  output logic                      led_blue,
  output logic                      led_error
);

  trs_io_pkg::cmd_action_t action;
  trs_io_pkg::flash_load_t z80_flash_load;
  logic [7:0]              trs_data;
  logic [7:0]              z80_latched;
  logic [7:0]              spi_data;

  esp_cmd_parser esp_cmd_parser_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .mosi           (mosi),
    .cs             (cs),
    .z80_latched    (z80_latched),
    .spi_data       (spi_data),
    .miso           (miso),
    .action         (action),
    .trs_data       (trs_data),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .led_error      (led_error)
  );

  z80_port_decode #(
    .esp_req_cycles (esp_req_cycles)
  ) z80_port_decode_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .z80_io         (z80_io),
    .trs_data       (trs_data),
    .spi_data       (spi_data),
    .esp_done       (esp_done),
    .z80_latched    (z80_latched),
    .z80_flash_load (z80_flash_load),
    .z80_rdata      (z80_rdata),
    .z80_wait       (z80_wait),
    .esp_req        (esp_req),
    .esp_s          (esp_s)
  );

  flash_spi_master #(
    .flash_half_log2 (flash_half_log2)
  ) flash_spi_master_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .z80_flash_load (z80_flash_load),
    .action         (action),
    .flash_so       (flash_so),
    .spi_data       (spi_data),
    .flash_cs_n     (flash_cs_n),
    .flash_sck      (flash_sck),
    .flash_si       (flash_si)
  );

endmodule

`default_nettype wire

//--- verilog/flash_spi_master.sv
`default_nettype none
`timescale 1ns/100ps

module flash_spi_master #(
  parameter int flash_half_log2 = 3
) (
  input  wire logic                   clk,
  input  wire logic                   cass_out_sel_n,
  input  wire trs_io_pkg::flash_load_t z80_flash_load,
  input  wire trs_io_pkg::cmd_action_t action,
  input  wire logic                   flash_so,
  output logic [7:0]                  spi_data,
  output logic                        flash_cs_n,
  output logic                        flash_sck,
  output logic                        flash_si
);

  import trs_io_pkg::*;

  // msb is the busy flag, the rest counts 16 half periods
  localparam int cnt_w = flash_half_log2 + 5;
  localparam logic [cnt_w-1:0] half_mask = cnt_w'((1 << flash_half_log2) - 1);

  logic             ctrl_cs;
  logic [7:0]       shift_reg;
  logic [cnt_w-1:0] cnt;
  logic             busy;
  logic             half_start;
  logic             ctrl_we;
  logic             data_we;
  logic [7:0]       ctrl_val;
  logic [7:0]       data_val;

  // Z80 has priority over the ESP
  assign ctrl_we  = z80_flash_load.ctrl_we ||
                    (action.valid && action.op == set_spi_ctrl_reg);
  assign data_we  = z80_flash_load.data_we ||
                    (action.valid && action.op == set_spi_data);
  assign ctrl_val = z80_flash_load.ctrl_we ? z80_flash_load.value : action.param;
  assign data_val = z80_flash_load.data_we ? z80_flash_load.value : action.param;

  assign busy       = cnt[cnt_w-1];
  assign half_start = ((cnt & half_mask) == '0);

  // only bit 7 (chip select) of the control byte is used
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      ctrl_cs <= 1'b0;
    end else if (ctrl_we) begin
      ctrl_cs <= ctrl_val[7];
    end
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      cnt      <= '0;
      flash_si <= 1'b0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      if (half_start && !cnt[flash_half_log2]) begin
        flash_si <= shift_reg[7];
      end
    end else if (data_we) begin
      cnt <= {1'b1, {(cnt_w-1){1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      if (half_start && cnt[flash_half_log2]) begin
        shift_reg <= {shift_reg[6:0], flash_so};
      end
    end else if (data_we) begin
      shift_reg <= data_val;
    end
  end

  assign spi_data   = shift_reg;
  assign flash_cs_n = ~ctrl_cs;
  assign flash_sck  = cnt[flash_half_log2];

endmodule

`default_nettype wire

//--- verilog/z80_port_decode.sv
`default_nettype none
`timescale 1ns/100ps

module z80_port_decode #(
  parameter int esp_req_cycles = 50
) (
  input  wire logic                   clk,
  input  wire logic                   cass_out_sel_n,
  input  wire trs_io_pkg::z80_io_t    z80_io,
  input  wire logic [7:0]             trs_data,
  input  wire logic [7:0]             spi_data,
  input  wire logic                   esp_done,
  output logic [7:0]                  z80_latched,
  output trs_io_pkg::flash_load_t     z80_flash_load,
  output logic [7:0]                  z80_rdata,
  output logic                        z80_wait,
  output logic                        esp_req,
  output trs_io_pkg::esp_op_e         esp_s
);

  import trs_io_pkg::*;

  localparam int cnt_w = $clog2(esp_req_cycles + 1);

  logic [1:0]       in_sync;
  logic [1:0]       out_sync;
  logic             in_prev;
  logic             out_prev;
  logic             in_start;
  logic             out_start;
  logic             trs_io_sel;
  logic [2:0]       done_sync;
  logic             done_rise;
  logic [cnt_w-1:0] req_cnt;

  // strobes are active low, sync them as active high
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      in_sync   <= 2'b00;
      out_sync  <= 2'b00;
      in_prev   <= 1'b0;
      out_prev  <= 1'b0;
      done_sync <= 3'b000;
    end else begin
      in_sync   <= {in_sync[0], ~z80_io.in_n};
      out_sync  <= {out_sync[0], ~z80_io.out_n};
      in_prev   <= in_sync[1];
      out_prev  <= out_sync[1];
      done_sync <= {done_sync[1:0], esp_done};
    end
  end

  assign in_start   = in_sync[1] & ~in_prev;
  assign out_start  = out_sync[1] & ~out_prev;
  assign trs_io_sel = (z80_io.port == port_trs_io);
  assign done_rise  = (done_sync[2:1] == 2'b01);

  // ESP request, WAIT and status code
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      req_cnt  <= '0;
      z80_wait <= 1'b0;
      esp_s    <= esp_idle;
    end else begin
      if (trs_io_sel && (in_start || out_start)) begin
        req_cnt  <= cnt_w'(esp_req_cycles);
        z80_wait <= 1'b1;
        esp_s    <= in_start ? trs_io_in : trs_io_out;
      end else begin
        if (req_cnt != '0) begin
          req_cnt <= req_cnt - 1'b1;
        end
        if (done_rise) begin
          z80_wait <= 1'b0;
          esp_s    <= esp_idle;
        end
      end
    end
  end

  assign esp_req = (req_cnt != '0);

  always_ff @(posedge clk) begin
    if (out_start && trs_io_sel) begin
      z80_latched <= z80_io.wdata;
    end
  end

  // writes to FC/FD go straight to the flash master
  assign z80_flash_load = '{
    ctrl_we: out_start && (z80_io.port == port_spi_ctrl),
    data_we: out_start && (z80_io.port == port_spi_data),
    value:   z80_io.wdata
  };

  always_comb begin
    case (z80_io.port)
      port_trs_io:   z80_rdata = trs_data;
      port_spi_data: z80_rdata = spi_data;
      default:       z80_rdata = 8'hFF;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/esp_cmd_parser.sv
`default_nettype none
`timescale 1ns/100ps

module esp_cmd_parser (
  input  wire logic                   clk,
  input  wire logic                   cass_out_sel_n,
  input  wire logic                   sck,
  input  wire logic                   mosi,
  input  wire logic                   cs,
  input  wire logic [7:0]             z80_latched,
  input  wire logic [7:0]             spi_data,
  output logic                        miso,
  output trs_io_pkg::cmd_action_t     action,
  output logic [7:0]                  trs_data,
  output logic                        led_red,
  output logic                        led_green,
  output logic                        led_blue,
  output logic                        led_error
);

  import trs_io_pkg::*;

  logic [7:0] rx_byte;
  logic       rx_valid;
  logic [7:0] reply;
  logic [1:0] op_info;
  cmd_state_e state;
  logic       act_valid;
  cmd_op_e    act_op;
  logic [7:0] act_param;

  // returns {known, takes one parameter byte}
  function automatic logic [1:0] lookup_op(input logic [7:0] code);
    case (code)
      get_cookie, dbus_read, get_version, get_spi_data: lookup_op = 2'b10;
      dbus_write, set_led, set_spi_ctrl_reg, set_spi_data: lookup_op = 2'b11;
      default: lookup_op = 2'b00;
    endcase
  endfunction

  esp_spi_slave spi_slave_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .mosi           (mosi),
    .cs             (cs),
    .reply          (reply),
    .miso           (miso),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid)
  );

  assign op_info = lookup_op(rx_byte);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state     <= idle;
      act_valid <= 1'b0;
      led_error <= 1'b0;
    end else begin
      act_valid <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: begin
            if (!op_info[1]) begin
              // sticky until reset
              led_error <= 1'b1;
            end else if (op_info[0]) begin
              state <= read_bytes;
            end else begin
              act_valid <= 1'b1;
            end
          end
          read_bytes: begin
            act_valid <= 1'b1;
            state     <= idle;
          end
          default: state <= idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid) begin
      if (state == idle) begin
        act_op <= cmd_op_e'(rx_byte);
      end else begin
        act_param <= rx_byte;
      end
    end
  end

  assign action = '{valid: act_valid, op: act_op, param: act_param};

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_red   <= 1'b0;
      led_green <= 1'b0;
      led_blue  <= 1'b0;
    end else if (act_valid && act_op == set_led) begin
      led_red   <= act_param[0];
      led_green <= act_param[1];
      led_blue  <= act_param[2];
    end
  end

  // reply goes out in the byte after the command
  always_ff @(posedge clk) begin
    if (act_valid) begin
      case (act_op)
        get_cookie:   reply <= cookie;
        get_version:  reply <= {version_major, version_minor};
        dbus_read:    reply <= z80_latched;
        get_spi_data: reply <= spi_data;
        default:      reply <= reply;
      endcase
      if (act_op == dbus_write) begin
        trs_data <= act_param;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/esp_spi_slave.sv
`default_nettype none
`timescale 1ns/100ps

module esp_spi_slave (
  input  wire logic       clk,
  input  wire logic       cass_out_sel_n,
  input  wire logic       sck,
  input  wire logic       mosi,
  input  wire logic       cs,
  input  wire logic [7:0] reply,
  output logic            miso,
  output logic [7:0]      rx_byte,
  output logic            rx_valid
);

  logic [2:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;

  // edges are taken from the two oldest sync stages
  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[1];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_sync  <= 3'b000;
      cs_sync   <= 2'b11;
      mosi_sync <= 2'b00;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[0], cs};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt  <= 3'd0;
      rx_valid <= 1'b0;
      tx_shift <= 8'h00;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= 3'd0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            rx_valid <= 1'b1;
          end
        end
        // reply is taken at the first falling edge of a byte
        if (sck_fall) begin
          if (bit_cnt == 3'd1) begin
            tx_shift <= reply;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_sync[1]};
    end
  end

  assign rx_byte = rx_shift;
  assign miso    = cs_active & tx_shift[7];

endmodule

`default_nettype wire

//--- verilog/trs_io_pkg.sv
`default_nettype none

package trs_io_pkg;

  // ESP command opcodes, numbered as on the ESP side
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    dbus_read        = 8'd3,
    dbus_write       = 8'd4,
    get_version      = 8'd15,
    set_led          = 8'd26,
    set_spi_ctrl_reg = 8'd29,
    set_spi_data     = 8'd30,
    get_spi_data     = 8'd31
  } cmd_op_e;

  // status code shown to the ESP on esp_s
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    esp_idle   = 4'd15
  } esp_op_e;

  typedef enum logic {
    idle,
    read_bytes
  } cmd_state_e;

  // Z80 I/O bus request, strobes active low
  typedef struct packed {
    logic [7:0] port;
    logic [7:0] wdata;
    logic       in_n;
    logic       out_n;
  } z80_io_t;

  typedef struct packed {
    logic       valid;
    cmd_op_e    op;
    logic [7:0] param;
  } cmd_action_t;

  typedef struct packed {
    logic       ctrl_we;
    logic       data_we;
    logic [7:0] value;
  } flash_load_t;

  localparam logic [7:0] cookie        = 8'hAF;
  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3;

  localparam logic [7:0] port_trs_io    = 8'h1F;
  localparam logic [7:0] port_spi_ctrl  = 8'hFC;
  localparam logic [7:0] port_spi_data  = 8'hFD;

endpackage

`default_nettype wire
